//--- verilog/csr_defs.svh
// Fixed widths, reset values, write masks and interrupt bits, included by every CSR bank file
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Data path
`define CSR_XLEN         32
`define CSR_MISA_RESET   32'h4010_1100 // MXL 32, I, M, U

// Write masks, a zero bit is never written
`define CSR_MASK_MSTATUS 32'h007E_19AA
`define CSR_MASK_MISA    32'h0030_1000
`define CSR_MASK_MIE     32'h0000_0888
`define CSR_MASK_ALIGN   32'hFFFF_FFFC // mtvec and mepc, word aligned

// Bit positions in mip and mie
`define CSR_IRQ_MEI      11
`define CSR_IRQ_MSI      3
`define CSR_IRQ_MTI      7

// Return address step of an interrupted instruction
`define CSR_INSN_STEP    32'd4

`endif

//--- verilog/csr_pkg.sv
// Types of the CSR register space, used by the decode, execute and read-out logic of the bank
`include "csr_defs.svh"

package csr_pkg;

    // Architectural CSR addresses handled by the bank
    typedef enum logic [11:0] {
        MSTATUS       = 12'h300,
        MISA          = 12'h301,
        MIE           = 12'h304,
        MTVEC         = 12'h305,
        MCOUNTINHIBIT = 12'h320,
        MSCRATCH      = 12'h340,
        MEPC          = 12'h341,
        MCAUSE        = 12'h342,
        MTVAL         = 12'h343,
        MIP           = 12'h344,
        MCYCLE        = 12'hB00,
        MINSTRET      = 12'hB02,
        MCYCLEH       = 12'hB80,
        MINSTRETH     = 12'hB82,
        CYCLE         = 12'hC00,   // User aliases, read only
        INSTRET       = 12'hC02,
        CYCLEH        = 12'hC80,
        INSTRETH      = 12'hC82,
        MVENDORID     = 12'hF11,   // Identity, reads zero
        MARCHID       = 12'hF12,
        MIMPID        = 12'hF13,
        MHARTID       = 12'hF14,
        MCONFIGPTR    = 12'hF15
    } csr_addr_e;

    typedef enum logic [1:0] {
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_e;

    // Internal register selector
    typedef enum logic [3:0] {
        SEL_NONE, SEL_ZERO, SEL_MSTATUS, SEL_MISA, SEL_MIE, SEL_MIP, SEL_MTVEC, SEL_MSCRATCH,
        SEL_MEPC, SEL_MCAUSE, SEL_MTVAL, SEL_MCOUNTINHIBIT, SEL_MCYCLE, SEL_MCYCLEH,
        SEL_MINSTRET, SEL_MINSTRETH
    } csr_sel_e;

    typedef struct packed {
        logic                 rd_en;
        logic                 wr_en;
        csr_op_e              op;
        logic [11:0]          addr;  // Raw address, may be unmapped
        logic [`CSR_XLEN-1:0] wdata;
    } csr_req_t;

endpackage

//--- verilog/trap_pkg.sv
// Trap types of the core: privilege levels, exception and interrupt codes and the trap event
`include "csr_defs.svh"

package trap_pkg;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'd0,
        PRIV_MACHINE = 2'd3
    } priv_e;

    typedef enum logic [4:0] {
        INSTR_MISALIGNED    = 5'd0,
        INSTR_ACCESS_FAULT  = 5'd1,
        ILLEGAL_INSTRUCTION = 5'd2,
        BREAKPOINT          = 5'd3,
        LOAD_MISALIGNED     = 5'd4,
        LOAD_ACCESS_FAULT   = 5'd5,
        STORE_MISALIGNED    = 5'd6,
        STORE_ACCESS_FAULT  = 5'd7,
        ECALL_FROM_U        = 5'd8,
        ECALL_FROM_M        = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        NO_INT    = 5'd0,
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

    typedef struct packed {
        logic                 mret;
        logic                 raise;      // Exception
        exc_code_e            exc_code;
        logic                 ack;        // Interrupt taken
        logic [`CSR_XLEN-1:0] pc;
        logic [`CSR_XLEN-1:0] instr;
        logic                 jump;
        logic [`CSR_XLEN-1:0] jump_target;
    } trap_evt_t;

endpackage

//--- verilog/csr_decode.sv
// CSR address decode: maps an access to a register selector and write mask, gated by kill
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_decode (
    input  csr_pkg::csr_req_t    req_i,
    input  logic                 kill_i,
    output csr_pkg::csr_sel_e    sel_o,
    output logic [`CSR_XLEN-1:0] wmask_o,
    output logic                 rd_en_o,
    output logic                 wr_en_o
);

    logic read_only;

    assign read_only = (req_i.addr[11:8] == 4'hC); // User counter aliases

    always_comb begin
        sel_o = csr_pkg::SEL_NONE;
        case (req_i.addr)
            csr_pkg::MSTATUS:       sel_o = csr_pkg::SEL_MSTATUS;
            csr_pkg::MISA:          sel_o = csr_pkg::SEL_MISA;
            csr_pkg::MIE:           sel_o = csr_pkg::SEL_MIE;
            csr_pkg::MIP:           sel_o = csr_pkg::SEL_MIP;
            csr_pkg::MTVEC:         sel_o = csr_pkg::SEL_MTVEC;
            csr_pkg::MSCRATCH:      sel_o = csr_pkg::SEL_MSCRATCH;
            csr_pkg::MEPC:          sel_o = csr_pkg::SEL_MEPC;
            csr_pkg::MCAUSE:        sel_o = csr_pkg::SEL_MCAUSE;
            csr_pkg::MTVAL:         sel_o = csr_pkg::SEL_MTVAL;
            csr_pkg::MCOUNTINHIBIT: sel_o = csr_pkg::SEL_MCOUNTINHIBIT;
            csr_pkg::MCYCLE,
            csr_pkg::CYCLE:         sel_o = csr_pkg::SEL_MCYCLE;
            csr_pkg::MCYCLEH,
            csr_pkg::CYCLEH:        sel_o = csr_pkg::SEL_MCYCLEH;
            csr_pkg::MINSTRET,
            csr_pkg::INSTRET:       sel_o = csr_pkg::SEL_MINSTRET;
            csr_pkg::MINSTRETH,
            csr_pkg::INSTRETH:      sel_o = csr_pkg::SEL_MINSTRETH;
            csr_pkg::MVENDORID, csr_pkg::MARCHID, csr_pkg::MIMPID,
            csr_pkg::MHARTID, csr_pkg::MCONFIGPTR:
                                    sel_o = csr_pkg::SEL_ZERO;
            default:                sel_o = csr_pkg::SEL_NONE;
        endcase
    end

    // Mask per register, zero for read-only and unmapped
    always_comb begin
        case (sel_o)
            csr_pkg::SEL_MSTATUS:   wmask_o = `CSR_MASK_MSTATUS;
            csr_pkg::SEL_MISA:      wmask_o = `CSR_MASK_MISA;
            csr_pkg::SEL_MIE:       wmask_o = `CSR_MASK_MIE;
            csr_pkg::SEL_MTVEC,
            csr_pkg::SEL_MEPC:      wmask_o = `CSR_MASK_ALIGN;
            csr_pkg::SEL_MSCRATCH, csr_pkg::SEL_MCAUSE, csr_pkg::SEL_MTVAL,
            csr_pkg::SEL_MCOUNTINHIBIT, csr_pkg::SEL_MCYCLE, csr_pkg::SEL_MCYCLEH,
            csr_pkg::SEL_MINSTRET, csr_pkg::SEL_MINSTRETH:
                                    wmask_o = '1;
            default:                wmask_o = '0;
        endcase
        if (read_only) begin
            wmask_o = '0;
        end
    end

    assign rd_en_o = req_i.rd_en && !kill_i;
    assign wr_en_o = req_i.wr_en && !kill_i && (wmask_o != '0); // Nothing to write otherwise

endmodule

//--- verilog/csr_execute.sv
// CSR modify step and machine status, trap and scratch registers with trap and return handling
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_execute (
    input  logic                      clk,
    input  logic                      reset_n,
    input  csr_pkg::csr_op_e          op_i,
    input  logic [`CSR_XLEN-1:0]      wdata_i,
    input  csr_pkg::csr_sel_e         sel_i,
    input  logic [`CSR_XLEN-1:0]      wmask_i,
    input  logic                      wr_en_i,
    input  logic [`CSR_XLEN-1:0]      cur_i,
    input  trap_pkg::trap_evt_t       trap_i,
    input  trap_pkg::irq_code_e       irq_code_i,
    output logic                      cnt_we_o,
    output csr_pkg::csr_sel_e         cnt_sel_o,
    output logic [`CSR_XLEN-1:0]      new_val_o,
    output logic [3:0]                mstatus_o,   // {MPP, MPIE, MIE}
    output logic [`CSR_XLEN-1:0]      misa_o,
    output logic [`CSR_XLEN-1:0]      mie_o,
    output logic [`CSR_XLEN-1:0]      mtvec_o,
    output logic [`CSR_XLEN-1:0]      mscratch_o,
    output logic [`CSR_XLEN-1:0]      mepc_o,
    output logic [`CSR_XLEN-1:0]      mcause_o,
    output logic [`CSR_XLEN-1:0]      mtval_o,
    output logic [`CSR_XLEN-1:0]      mcountinhibit_o,
    output trap_pkg::priv_e           privilege_o
);

    logic [`CSR_XLEN-1:0] new_val;
    logic                 trap_entry, write_ok;
    logic                 mstatus_mie_q, mstatus_mpie_q;
    trap_pkg::priv_e      mstatus_mpp_q, priv_q;

    //////////////////////////////////////////////////////////////////////
    // Modify step
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op_i)
            csr_pkg::CSR_SET:   new_val = cur_i | (wdata_i & wmask_i);
            csr_pkg::CSR_CLEAR: new_val = cur_i & ~(wdata_i & wmask_i);
            default:            new_val = (cur_i & ~wmask_i) | (wdata_i & wmask_i);
        endcase
    end

    assign trap_entry = trap_i.raise || trap_i.ack;
    assign write_ok   = wr_en_i && !trap_i.mret && !trap_entry; // Lowest priority

    assign cnt_we_o  = write_ok;
    assign cnt_sel_o = sel_i;
    assign new_val_o = new_val;

    //////////////////////////////////////////////////////////////////////
    // Registers, one event per cycle
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mstatus_mie_q   <= 1'b0;
            mstatus_mpie_q  <= 1'b0;
            mstatus_mpp_q   <= trap_pkg::PRIV_MACHINE;
            priv_q          <= trap_pkg::PRIV_MACHINE;
            misa_o          <= `CSR_MISA_RESET;
            mie_o           <= '0;
            mtvec_o         <= '0;
            mscratch_o      <= '0;
            mepc_o          <= '0;
            mcause_o        <= '0;
            mtval_o         <= '0;
            mcountinhibit_o <= '0;
        end else if (trap_i.mret) begin
            mstatus_mie_q <= mstatus_mpie_q;
            priv_q        <= mstatus_mpp_q;
        end else if (trap_entry) begin
            mstatus_mpie_q <= mstatus_mie_q;
            mstatus_mie_q  <= 1'b0;
            mstatus_mpp_q  <= priv_q;
            priv_q         <= trap_pkg::PRIV_MACHINE;
            if (trap_i.raise) begin
                mcause_o <= {1'b0, {(`CSR_XLEN-6){1'b0}}, trap_i.exc_code};
                mepc_o   <= trap_i.pc;
                mtval_o  <= (trap_i.exc_code == trap_pkg::ILLEGAL_INSTRUCTION)
                            ? trap_i.instr : trap_i.pc;
            end else begin
                // Interrupted instruction retires, resume after it
                mcause_o <= {1'b1, {(`CSR_XLEN-6){1'b0}}, irq_code_i};
                mepc_o   <= trap_i.jump ? trap_i.jump_target : trap_i.pc + `CSR_INSN_STEP;
            end
        end else if (write_ok) begin
            case (sel_i)
                csr_pkg::SEL_MSTATUS: begin
                    mstatus_mpp_q  <= trap_pkg::priv_e'(new_val[12:11]);
                    mstatus_mpie_q <= new_val[7];
                    mstatus_mie_q  <= new_val[3];
                end
                csr_pkg::SEL_MISA:          misa_o          <= new_val;
                csr_pkg::SEL_MIE:           mie_o           <= new_val;
                csr_pkg::SEL_MTVEC:         mtvec_o         <= new_val;
                csr_pkg::SEL_MSCRATCH:      mscratch_o      <= new_val;
                csr_pkg::SEL_MEPC:          mepc_o          <= new_val;
                csr_pkg::SEL_MCAUSE:        mcause_o        <= new_val;
                csr_pkg::SEL_MTVAL:         mtval_o         <= new_val;
                csr_pkg::SEL_MCOUNTINHIBIT: mcountinhibit_o <= new_val;
                default: ; // Counters live in csr_counters
            endcase
        end
    end

    assign mstatus_o   = {mstatus_mpp_q, mstatus_mpie_q, mstatus_mie_q};
    assign privilege_o = priv_q;

    // Decode mask keeps the trap vector word aligned
    a_mtvec_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        mtvec_o[1:0] == 2'b00);

    a_trap_to_machine: assert property (@(posedge clk) disable iff (!reset_n)
        trap_entry && !trap_i.mret |=> priv_q == trap_pkg::PRIV_MACHINE);

endmodule

//--- verilog/csr_counters.sv
// 64-bit mcycle and minstret counters with half-word writes through the CSR port
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_counters (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 we_i,
    input  csr_pkg::csr_sel_e    sel_i,
    input  logic [`CSR_XLEN-1:0] wdata_i,
    input  logic                 kill_i,
    input  logic                 hold_i,
    output logic [63:0]          mcycle_o,
    output logic [63:0]          minstret_o
);

    logic [63:0] mcycle_inc, minstret_inc;

    assign mcycle_inc   = mcycle_o + 64'd1;
    assign minstret_inc = (kill_i || hold_i) ? minstret_o : minstret_o + 64'd1; // Retired only

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mcycle_o   <= '0;
            minstret_o <= '0;
        end else begin
            mcycle_o   <= mcycle_inc;
            minstret_o <= minstret_inc;
            // Written half takes the data, the other half keeps counting
            if (we_i) begin
                case (sel_i)
                    csr_pkg::SEL_MCYCLE:    mcycle_o   <= {mcycle_inc[63:`CSR_XLEN], wdata_i};
                    csr_pkg::SEL_MCYCLEH:   mcycle_o   <= {wdata_i, mcycle_inc[`CSR_XLEN-1:0]};
                    csr_pkg::SEL_MINSTRET:  minstret_o <= {minstret_inc[63:`CSR_XLEN], wdata_i};
                    csr_pkg::SEL_MINSTRETH: minstret_o <= {wdata_i, minstret_inc[`CSR_XLEN-1:0]};
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- verilog/irq_control.sv
// Machine interrupt control: registers the lines into mip, raises pending and picks the cause
`timescale 1ns/1ps
`include "csr_defs.svh"

module irq_control (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic [`CSR_XLEN-1:0] irq_i,
    input  logic [`CSR_XLEN-1:0] mie_i,
    input  logic                 mstatus_mie_i,
    input  logic                 ack_i,
    output logic [`CSR_XLEN-1:0] mip_o,
    output logic                 pending_o,
    output trap_pkg::irq_code_e  code_o
);

    logic [`CSR_XLEN-1:0] active;

    assign active = mip_o & mie_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mip_o <= '0;
        end else begin
            mip_o <= irq_i;
        end
    end

    // Pending one cycle after enable and line overlap
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pending_o <= 1'b0;
            code_o    <= trap_pkg::NO_INT;
        end else if (mstatus_mie_i && (active != '0) && !ack_i) begin
            pending_o <= 1'b1;
            if (active[`CSR_IRQ_MEI]) begin        // External first
                code_o <= trap_pkg::M_EXT_INT;
            end else if (active[`CSR_IRQ_MSI]) begin
                code_o <= trap_pkg::M_SW_INT;
            end else if (active[`CSR_IRQ_MTI]) begin
                code_o <= trap_pkg::M_TIM_INT;
            end
        end else begin
            pending_o <= 1'b0;
        end
    end

    // No second request while the core enters the handler
    a_ack_clears: assert property (@(posedge clk) disable iff (!reset_n)
        ack_i |=> !pending_o);

endmodule

//--- verilog/csr_result.sv
// CSR read-out: current value of the selected register and the read data gated by read enable
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_result (
    input  csr_pkg::csr_sel_e    sel_i,
    input  logic                 rd_en_i,
    input  logic [3:0]           mstatus_i,
    input  logic [`CSR_XLEN-1:0] misa_i,
    input  logic [`CSR_XLEN-1:0] mie_i,
    input  logic [`CSR_XLEN-1:0] mip_i,
    input  logic [`CSR_XLEN-1:0] mtvec_i,
    input  logic [`CSR_XLEN-1:0] mscratch_i,
    input  logic [`CSR_XLEN-1:0] mepc_i,
    input  logic [`CSR_XLEN-1:0] mcause_i,
    input  logic [`CSR_XLEN-1:0] mtval_i,
    input  logic [`CSR_XLEN-1:0] mcountinhibit_i,
    input  logic [63:0]          mcycle_i,
    input  logic [63:0]          minstret_i,
    output logic [`CSR_XLEN-1:0] cur_o,
    output logic [`CSR_XLEN-1:0] data_o
);

    logic [`CSR_XLEN-1:0] mstatus;

    // MPP at 12:11, MPIE at 7, MIE at 3, the rest reads zero
    always_comb begin
        mstatus        = '0;
        mstatus[12:11] = mstatus_i[3:2];
        mstatus[7]     = mstatus_i[1];
        mstatus[3]     = mstatus_i[0];
    end

    always_comb begin
        case (sel_i)
            csr_pkg::SEL_MSTATUS:       cur_o = mstatus;
            csr_pkg::SEL_MISA:          cur_o = misa_i;
            csr_pkg::SEL_MIE:           cur_o = mie_i;
            csr_pkg::SEL_MIP:           cur_o = mip_i;
            csr_pkg::SEL_MTVEC:         cur_o = mtvec_i;
            csr_pkg::SEL_MSCRATCH:      cur_o = mscratch_i;
            csr_pkg::SEL_MEPC:          cur_o = mepc_i;
            csr_pkg::SEL_MCAUSE:        cur_o = mcause_i;
            csr_pkg::SEL_MTVAL:         cur_o = mtval_i;
            csr_pkg::SEL_MCOUNTINHIBIT: cur_o = mcountinhibit_i;
            csr_pkg::SEL_MCYCLE:        cur_o = mcycle_i[`CSR_XLEN-1:0];
            csr_pkg::SEL_MCYCLEH:       cur_o = mcycle_i[63:`CSR_XLEN];
            csr_pkg::SEL_MINSTRET:      cur_o = minstret_i[`CSR_XLEN-1:0];
            csr_pkg::SEL_MINSTRETH:     cur_o = minstret_i[63:`CSR_XLEN];
            default:                    cur_o = '0; // Identity and unmapped
        endcase
    end

    assign data_o = rd_en_i ? cur_o : '0;

endmodule

//--- verilog/csr_bank.sv
// Top of the machine-mode CSR bank, connecting decode, execute, counters, interrupts and read-out
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_bank (
    input  logic                 clk,
    input  logic                 reset_n,
    input  csr_pkg::csr_req_t    req_i,
    input  logic                 kill_i,
    input  logic                 hold_i,
    input  trap_pkg::trap_evt_t  trap_i,
    input  logic [`CSR_XLEN-1:0] irq_i,
    output logic [`CSR_XLEN-1:0] data_o,
    output logic                 interrupt_pending_o,
    output trap_pkg::priv_e      privilege_o,
    output logic [`CSR_XLEN-1:0] mepc_o,
    output logic [`CSR_XLEN-1:0] mtvec_o
);

    csr_pkg::csr_sel_e    sel, cnt_sel;
    trap_pkg::irq_code_e  irq_code;
    logic [`CSR_XLEN-1:0] wmask, cur, new_val;
    logic                 rd_en, wr_en, cnt_we;
    logic [3:0]           mstatus;
    logic [`CSR_XLEN-1:0] misa, mie, mip, mscratch, mcause, mtval, mcountinhibit;
    logic [63:0]          mcycle, minstret;

    csr_decode decode_i (
        .req_i(req_i), .kill_i(kill_i),
        .sel_o(sel), .wmask_o(wmask), .rd_en_o(rd_en), .wr_en_o(wr_en)
    );

    csr_execute execute_i (
        .clk(clk), .reset_n(reset_n),
        .op_i(req_i.op), .wdata_i(req_i.wdata), .sel_i(sel), .wmask_i(wmask),
        .wr_en_i(wr_en), .cur_i(cur), .trap_i(trap_i), .irq_code_i(irq_code),
        .cnt_we_o(cnt_we), .cnt_sel_o(cnt_sel), .new_val_o(new_val),
        .mstatus_o(mstatus), .misa_o(misa), .mie_o(mie), .mtvec_o(mtvec_o),
        .mscratch_o(mscratch), .mepc_o(mepc_o), .mcause_o(mcause), .mtval_o(mtval),
        .mcountinhibit_o(mcountinhibit), .privilege_o(privilege_o)
    );

    csr_counters counters_i (
        .clk(clk), .reset_n(reset_n),
        .we_i(cnt_we), .sel_i(cnt_sel), .wdata_i(new_val),
        .kill_i(kill_i), .hold_i(hold_i),
        .mcycle_o(mcycle), .minstret_o(minstret)
    );

    irq_control irq_i0 (
        .clk(clk), .reset_n(reset_n),
        .irq_i(irq_i), .mie_i(mie), .mstatus_mie_i(mstatus[0]), .ack_i(trap_i.ack),
        .mip_o(mip), .pending_o(interrupt_pending_o), .code_o(irq_code)
    );

    csr_result result_i (
        .sel_i(sel), .rd_en_i(rd_en),
        .mstatus_i(mstatus), .misa_i(misa), .mie_i(mie), .mip_i(mip),
        .mtvec_i(mtvec_o), .mscratch_i(mscratch), .mepc_i(mepc_o), .mcause_i(mcause),
        .mtval_i(mtval), .mcountinhibit_i(mcountinhibit),
        .mcycle_i(mcycle), .minstret_i(minstret),
        .cur_o(cur), .data_o(data_o)
    );

endmodule

//--- tb/csr_bank_tb.sv
// Self-checking testbench of the CSR bank that runs random accesses, traps and interrupts against a model
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_bank_tb;

    localparam int N_ACC        = 600;
    localparam int N_TRAP       = 400;
    localparam int N_IRQ        = 400;
    localparam int TOTAL_CYCLES = 10 + N_ACC + N_TRAP + N_IRQ + 80;

    logic                 clk;
    logic                 reset_n;
    csr_pkg::csr_req_t    req;
    logic                 kill, hold;
    trap_pkg::trap_evt_t  trap;
    logic [31:0]          irq;
    logic [31:0]          data_o, mepc_o, mtvec_o;
    logic                 pending_o;
    trap_pkg::priv_e      privilege_o;

    logic [31:0] seed = 32'h0781_f6ad;
    logic        check_en;
    string       test_name;

    // Model state
    logic [1:0]  m_mpp, m_priv;
    logic        m_mpie, m_mie_b, m_pending;
    logic [4:0]  m_code;
    logic [31:0] m_misa, m_mie, m_mip, m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval;
    logic [31:0] m_mcinh;
    logic [63:0] m_mcycle, m_minstret;

    logic [11:0] addr_tab [16] = '{12'h300, 12'h301, 12'h304, 12'h305, 12'h340, 12'h341,
        12'h342, 12'h343, 12'h320, 12'h344, 12'hB00, 12'hB82, 12'hC00, 12'hC82, 12'hF11,
        12'h7C0};
    logic [4:0]  exc_tab [8] = '{5'd0, 5'd1, 5'd2, 5'd2, 5'd5, 5'd7, 5'd8, 5'd11};

    csr_bank dut_i (
        .clk(clk), .reset_n(reset_n), .req_i(req), .kill_i(kill), .hold_i(hold),
        .trap_i(trap), .irq_i(irq), .data_o(data_o), .interrupt_pending_o(pending_o),
        .privilege_o(privilege_o), .mepc_o(mepc_o), .mtvec_o(mtvec_o)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s %s expected %h actual %h", test_name, what, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] mask_of(input logic [11:0] a);
        case (a)
            12'h300: return `CSR_MASK_MSTATUS;
            12'h301: return `CSR_MASK_MISA;
            12'h304: return `CSR_MASK_MIE;
            12'h305, 12'h341: return `CSR_MASK_ALIGN;
            12'h340, 12'h342, 12'h343, 12'h320,
            12'hB00, 12'hB02, 12'hB80, 12'hB82: return 32'hFFFF_FFFF;
            default: return 32'h0; // Read-only, identity, unmapped
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] a);
        logic [31:0] st;
        st = 32'h0;
        st[12:11] = m_mpp;
        st[7] = m_mpie;
        st[3] = m_mie_b;
        case (a)
            12'h300: return st;
            12'h301: return m_misa;
            12'h304: return m_mie;
            12'h305: return m_mtvec;
            12'h320: return m_mcinh;
            12'h340: return m_mscratch;
            12'h341: return m_mepc;
            12'h342: return m_mcause;
            12'h343: return m_mtval;
            12'h344: return m_mip;
            12'hB00, 12'hC00: return m_mcycle[31:0];
            12'hB80, 12'hC80: return m_mcycle[63:32];
            12'hB02, 12'hC02: return m_minstret[31:0];
            12'hB82, 12'hC82: return m_minstret[63:32];
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] modify(input csr_pkg::csr_op_e op, input logic [31:0] cur,
                                           input logic [31:0] wd, input logic [31:0] m);
        case (op)
            csr_pkg::CSR_SET:   return cur | (wd & m);
            csr_pkg::CSR_CLEAR: return cur & ~(wd & m);
            default:            return (cur & ~m) | (wd & m);
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Model updated on the same edge as the DUT
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk or negedge reset_n) begin : model_update
        logic [31:0] m, nv, act;
        logic        wr_ok;
        logic [63:0] cyc_inc, ins_inc;
        if (!reset_n) begin
            m_mpp <= 2'd3;
            m_priv <= 2'd3;
            m_mpie <= 1'b0;
            m_mie_b <= 1'b0;
            m_pending <= 1'b0;
            m_code <= 5'd0;
            m_misa <= `CSR_MISA_RESET;
            m_mie <= '0;
            m_mip <= '0;
            m_mtvec <= '0;
            m_mscratch <= '0;
            m_mepc <= '0;
            m_mcause <= '0;
            m_mtval <= '0;
            m_mcinh <= '0;
            m_mcycle <= '0;
            m_minstret <= '0;
        end else begin
            m = mask_of(req.addr);
            nv = modify(req.op, model_read(req.addr), req.wdata, m);
            wr_ok = req.wr_en && !kill && (m != 32'h0) && !trap.mret && !trap.raise
                    && !trap.ack;
            cyc_inc = m_mcycle + 64'd1;
            ins_inc = (kill || hold) ? m_minstret : m_minstret + 64'd1;
            m_mcycle <= cyc_inc;
            m_minstret <= ins_inc;
            m_mip <= irq;
            act = m_mip & m_mie;
            if (m_mie_b && (act != 32'h0) && !trap.ack) begin
                m_pending <= 1'b1;
                if (act[11]) begin           // External before software before timer
                    m_code <= 5'd11;
                end else if (act[3]) begin
                    m_code <= 5'd3;
                end else if (act[7]) begin
                    m_code <= 5'd7;
                end
            end else begin
                m_pending <= 1'b0;
            end
            if (trap.mret) begin
                m_mie_b <= m_mpie;
                m_priv <= m_mpp;
            end else if (trap.raise || trap.ack) begin
                m_mpie <= m_mie_b;
                m_mie_b <= 1'b0;
                m_mpp <= m_priv;
                m_priv <= 2'd3;
                if (trap.raise) begin
                    m_mcause <= {27'h0, trap.exc_code};
                    m_mepc <= trap.pc;
                    m_mtval <= (trap.exc_code == trap_pkg::ILLEGAL_INSTRUCTION)
                               ? trap.instr : trap.pc;
                end else begin
                    m_mcause <= {1'b1, 26'h0, m_code};
                    m_mepc <= trap.jump ? trap.jump_target : trap.pc + 32'd4;
                end
            end else if (wr_ok) begin
                case (req.addr)
                    12'h300: begin
                        m_mpp <= nv[12:11];
                        m_mpie <= nv[7];
                        m_mie_b <= nv[3];
                    end
                    12'h301: m_misa <= nv;
                    12'h304: m_mie <= nv;
                    12'h305: m_mtvec <= nv;
                    12'h320: m_mcinh <= nv;
                    12'h340: m_mscratch <= nv;
                    12'h341: m_mepc <= nv;
                    12'h342: m_mcause <= nv;
                    12'h343: m_mtval <= nv;
                    12'hB00: m_mcycle <= {cyc_inc[63:32], nv};
                    12'hB80: m_mcycle <= {nv, cyc_inc[31:0]};
                    12'hB02: m_minstret <= {ins_inc[63:32], nv};
                    12'hB82: m_minstret <= {nv, ins_inc[31:0]};
                    default: ;
                endcase
            end
        end
    end

    // Outputs are settled half a period after the drive edge
    always @(negedge clk) begin
        if (check_en) begin
            check("data_o", (req.rd_en && !kill) ? model_read(req.addr) : 32'h0, data_o);
            check("privilege_o", {30'h0, m_priv}, {30'h0, privilege_o});
            check("interrupt_pending_o", {31'h0, m_pending}, {31'h0, pending_o});
            check("mepc_o", m_mepc, mepc_o);
            check("mtvec_o", m_mtvec, mtvec_o);
        end
    end

    task automatic access(input logic rd, input logic wr, input logic [1:0] op,
                          input logic [11:0] addr, input logic [31:0] wd);
        csr_pkg::csr_req_t v;
        @(posedge clk);
        v = '0;
        v.rd_en = rd;
        v.wr_en = wr;
        v.op = csr_pkg::csr_op_e'(op);
        v.addr = addr;
        v.wdata = wd;
        req <= v;
        kill <= 1'b0;
        hold <= 1'b0;
        trap <= '0;
    endtask

    task automatic random_cycle(input logic traps, input logic irqs);
        csr_pkg::csr_req_t   v;
        trap_pkg::trap_evt_t t;
        logic [31:0]         r, r2;
        @(posedge clk);
        r = next_rand();
        r2 = next_rand();
        v = '0;
        v.rd_en = r[6];
        v.wr_en = r[7];
        v.op = csr_pkg::csr_op_e'((r[5:4] == 2'd0) ? 2'd1 : r[5:4]);
        v.addr = addr_tab[r[3:0]];
        v.wdata = next_rand();
        t = '0;
        if (traps) begin
            t.mret = (r[11:8] == 4'd0);
            t.raise = (r[11:8] == 4'd1);
            t.ack = irqs && (m_pending ? r[12] : (r[11:8] == 4'd2));
            t.exc_code = trap_pkg::exc_code_e'(exc_tab[r[15:13]]);
            t.pc = next_rand();
            t.instr = next_rand();
            t.jump = r[16];
            t.jump_target = next_rand();
        end
        req <= v;
        kill <= (r[19:17] == 3'd0);
        hold <= (r[21:20] == 2'd0);
        trap <= t;
        if (irqs && r2[2:0] == 3'd0) begin
            irq <= (r2 & 32'h0000_0888) | {24'h0, r2[31:29], 5'h0};
        end
    endtask

    initial begin : watchdog
        #(TOTAL_CYCLES * 4 + 400);
        $display("Timeout: the testbench did not finish in time");
        $display("*** TEST FAILED ***");
        $fatal(1);
    end

    initial begin : main
        logic [31:0] c1;
        clk = 1'b0;
        reset_n = 1'b0;
        req = '0;
        kill = 1'b0;
        hold = 1'b0;
        trap = '0;
        irq = '0;
        check_en = 1'b0;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        check_en <= 1'b1;

        test_name = "reset";
        access(1'b1, 1'b0, 2'd1, 12'h301, 32'h0);
        @(negedge clk);
        check("misa", `CSR_MISA_RESET, data_o);
        check("privilege", 32'd3, {30'h0, privilege_o});
        check("pending", 32'h0, {31'h0, pending_o});
        for (int i = 11; i < 16; i++) begin
            access(1'b1, 1'b0, 2'd1, addr_tab[i], 32'h0);
        end

        test_name = "random_access";
        repeat (N_ACC) random_cycle(1'b0, 1'b0);

        test_name = "trap_return";
        repeat (N_TRAP) random_cycle(1'b1, 1'b0);

        // Enables on and then one timer line
        test_name = "irq_latency";
        access(1'b0, 1'b1, 2'd1, 12'h304, 32'h0000_0888);
        access(1'b0, 1'b1, 2'd2, 12'h300, 32'h0000_0008);
        repeat (3) access(1'b0, 1'b0, 2'd1, 12'h0, 32'h0);
        @(posedge clk);
        irq <= 32'h0000_0080;
        @(negedge clk);                      // Line driven, not yet sampled
        @(negedge clk);
        check("pending after 1", 32'h0, {31'h0, pending_o});
        @(negedge clk);
        check("pending after 2", 32'h1, {31'h0, pending_o});

        test_name = "interrupts";
        repeat (N_IRQ) random_cycle(1'b1, 1'b1);

        test_name = "counters";
        irq <= '0;
        access(1'b1, 1'b0, 2'd1, 12'hB00, 32'h0);
        @(negedge clk);
        c1 = data_o;
        repeat (36) access(1'b0, 1'b0, 2'd1, 12'h0, 32'h0);
        access(1'b1, 1'b0, 2'd1, 12'hB00, 32'h0);
        @(negedge clk);
        check("mcycle delta", 32'd37, data_o - c1);
        access(1'b0, 1'b1, 2'd1, 12'hB82, 32'h1234_5678);
        access(1'b1, 1'b0, 2'd1, 12'hB82, 32'h0);
        repeat (4) access(1'b1, 1'b0, 2'd1, 12'hB02, 32'h0);

        @(posedge clk);
        check_en <= 1'b0;
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/trap_pkg.sv
verilog/csr_decode.sv
verilog/csr_execute.sv
verilog/csr_counters.sv
verilog/irq_control.sv
verilog/csr_result.sv
verilog/csr_bank.sv
tb/csr_bank_tb.sv

//--- Makefile
# Verilator build and run of the CSR bank testbench

TOP := csr_bank_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build folder"
	@echo "  help   list the targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
